/* common/arm_isa_pkg.sv */
package arm_isa_pkg;

  // Raw encoding field widths
  typedef logic [31:0] instr_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [7:0]  imm8_t;
  typedef logic [3:0]  rotate_t;
  typedef logic [4:0]  shamt_t;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } condition_t;

  typedef enum logic [1:0] {
    SHIFT_LSL,
    SHIFT_LSR,
    SHIFT_ASR,
    SHIFT_ROR
  } shift_type_t;

  // Data-processing opcode, bits 24:21
  typedef enum logic [3:0] {
    OP_AND, OP_EOR, OP_SUB, OP_RSB,
    OP_ADD, OP_ADC, OP_SBC, OP_RSC,
    OP_TST, OP_TEQ, OP_CMP, OP_CMN,
    OP_ORR, OP_MOV, OP_BIC, OP_MVN
  } dp_opcode_t;

  typedef enum logic [4:0] {
    ARM_INSTR_BX,
    ARM_INSTR_BLOCK_TRANSFER,
    ARM_INSTR_BRANCH,
    ARM_INSTR_BRANCH_LINK,
    ARM_INSTR_SWI,
    ARM_INSTR_SINGLE_TRANSFER,
    ARM_INSTR_SWAP,
    ARM_INSTR_MUL,
    ARM_INSTR_MUL_LONG,
    ARM_INSTR_HALF_REG,
    ARM_INSTR_HALF_IMM,
    ARM_INSTR_MRS,
    ARM_INSTR_MSR,
    ARM_INSTR_DATAPROC_IMM,
    ARM_INSTR_DATAPROC_REG_IMM,
    ARM_INSTR_DATAPROC_REG_REG,
    ARM_INSTR_UNDEFINED
  } instr_type_t;

endpackage : arm_isa_pkg

/* common/core_pkg.sv */
package core_pkg;

  typedef logic [31:0] word_t;

  // N, Z, C, V from msb to lsb
  typedef logic [3:0] flags_t;

  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  localparam int NUM_REGS = 16;

endpackage : core_pkg

/* decoder/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import arm_isa_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        instr_valid,
  input  instr_t      instr,
  output logic        dec_valid,
  output condition_t  cond,
  output instr_type_t instr_type,
  output reg_idx_t    rn,
  output reg_idx_t    rd,
  output reg_idx_t    rs,
  output reg_idx_t    rm,
  output dp_opcode_t  opcode,
  output logic        set_flags,
  output imm8_t       imm8,
  output rotate_t     rotate,
  output shamt_t      shamt,
  output shift_type_t shift_type
);

  instr_type_t next_type;

  // Class match in priority order, data processing last
  always_comb begin
    priority casez (instr)
      32'b????_0001_0010_1111_1111_1111_0001_????: next_type = ARM_INSTR_BX;
      32'b????_100?_????_????_????_????_????_????: next_type = ARM_INSTR_BLOCK_TRANSFER;
      32'b????_1010_????_????_????_????_????_????: next_type = ARM_INSTR_BRANCH;
      32'b????_1011_????_????_????_????_????_????: next_type = ARM_INSTR_BRANCH_LINK;
      32'b????_1111_????_????_????_????_????_????: next_type = ARM_INSTR_SWI;
      // Register offset with bit 4 set is the architectural undefined hole
      32'b????_011?_????_????_????_????_???1_????: next_type = ARM_INSTR_UNDEFINED;
      32'b????_01??_????_????_????_????_????_????: next_type = ARM_INSTR_SINGLE_TRANSFER;
      32'b????_0001_0???_????_????_0000_1001_????: next_type = ARM_INSTR_SWAP;
      32'b????_0000_0???_????_????_????_1001_????: next_type = ARM_INSTR_MUL;
      32'b????_0000_1???_????_????_????_1001_????: next_type = ARM_INSTR_MUL_LONG;
      32'b????_000?_?0??_????_????_0000_1??1_????: next_type = ARM_INSTR_HALF_REG;
      32'b????_000?_?1??_????_????_????_1??1_????: next_type = ARM_INSTR_HALF_IMM;
      // PSR transfers sit in the compare opcodes with S clear
      32'b????_0001_0?00_1111_????_????_????_????: next_type = ARM_INSTR_MRS;
      32'b????_00?1_0?10_????_1111_????_????_????: next_type = ARM_INSTR_MSR;
      32'b????_00??_????_????_????_????_????_????: begin
        // I bit picks immediate, then bit 4 picks shift source
        if (instr[25]) begin
          next_type = ARM_INSTR_DATAPROC_IMM;
        end else if (!instr[4]) begin
          next_type = ARM_INSTR_DATAPROC_REG_IMM;
        end else begin
          next_type = ARM_INSTR_DATAPROC_REG_REG;
        end
      end
      default: next_type = ARM_INSTR_UNDEFINED;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
    end
  end

  // Field extraction is form independent, execute ignores what it does not need
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      cond       <= condition_t'(instr[31:28]);
      instr_type <= next_type;
      rn         <= instr[19:16];
      rd         <= instr[15:12];
      rs         <= instr[11:8];
      rm         <= instr[3:0];
      opcode     <= dp_opcode_t'(instr[24:21]);
      set_flags  <= instr[20];
      imm8       <= instr[7:0];
      rotate     <= instr[11:8];
      shamt      <= instr[11:7];
      shift_type <= shift_type_t'(instr[6:5]);
    end
  end

  // A valid decode always carries a known class
  a_type_known : assert property (
    @(posedge clk) disable iff (reset)
    dec_valid |-> !$isunknown(instr_type)
  );

endmodule : instr_decoder

/* execute/operand_shifter.sv */
`timescale 1ns/1ps

module operand_shifter import arm_isa_pkg::*; import core_pkg::*; (
  input  instr_type_t form,
  input  word_t       rm_data,
  input  imm8_t       rs_byte,
  input  shamt_t      shamt,
  input  shift_type_t shift_type,
  input  imm8_t       imm8,
  input  rotate_t     rotate,
  input  logic        carry_in,
  output word_t       operand,
  output logic        carry_out
);

  // Returns {carry, value} for a shift by a full byte amount
  function automatic logic [32:0] shift_word(input word_t value, input shift_type_t kind,
                                             input logic [7:0] amount, input logic cin);
    word_t      res;
    logic       c;
    logic [4:0] low;
    low = amount[4:0];
    res = value;
    c   = cin;
    if (amount != 8'd0) begin
      case (kind)
        SHIFT_LSL: begin
          res = (amount < 8'd32) ? value << low : '0;
          if (amount < 8'd32) c = value[32 - int'(low)];
          else c = (amount == 8'd32) ? value[0] : 1'b0;
        end
        SHIFT_LSR: begin
          res = (amount < 8'd32) ? value >> low : '0;
          if (amount < 8'd32) c = value[low - 5'd1];
          else c = (amount == 8'd32) ? value[31] : 1'b0;
        end
        SHIFT_ASR: begin
          res = (amount < 8'd32) ? word_t'($signed(value) >>> low) : {32{value[31]}};
          c   = (amount < 8'd32) ? value[low - 5'd1] : value[31];
        end
        default: begin
          // Multiples of 32 keep the value and expose bit 31
          if (low == 5'd0) begin
            c = value[31];
          end else begin
            res = (value >> low) | (value << (6'd32 - {1'b0, low}));
            c   = value[low - 5'd1];
          end
        end
      endcase
    end
    return {c, res};
  endfunction

  logic [4:0]  rot_amt;
  word_t       imm_word;
  word_t       imm_rot;
  logic [7:0]  imm_shift_amt;
  logic [32:0] shifted;

  always_comb begin
    rot_amt  = {rotate, 1'b0};
    imm_word = {24'd0, imm8};
    imm_rot  = (imm_word >> rot_amt) | (imm_word << (6'd32 - {1'b0, rot_amt}));

    // LSR #0 and ASR #0 encode a shift of 32
    imm_shift_amt = {3'd0, shamt};
    if (shamt == 5'd0 && (shift_type == SHIFT_LSR || shift_type == SHIFT_ASR)) begin
      imm_shift_amt = 8'd32;
    end

    shifted = {carry_in, rm_data};
    case (form)
      ARM_INSTR_DATAPROC_IMM: begin
        shifted = {(rotate != 4'd0) ? imm_rot[31] : carry_in, imm_rot};
      end
      ARM_INSTR_DATAPROC_REG_IMM: begin
        if (shift_type == SHIFT_ROR && shamt == 5'd0) begin
          // RRX
          shifted = {rm_data[0], carry_in, rm_data[31:1]};
        end else begin
          shifted = shift_word(rm_data, shift_type, imm_shift_amt, carry_in);
        end
      end
      ARM_INSTR_DATAPROC_REG_REG: begin
        shifted = shift_word(rm_data, shift_type, rs_byte, carry_in);
      end
      default: begin
      end
    endcase

    carry_out = shifted[32];
    operand   = shifted[31:0];
  end

endmodule : operand_shifter

/* execute/dp_alu.sv */
`timescale 1ns/1ps

module dp_alu import arm_isa_pkg::*; import core_pkg::*; (
  input  dp_opcode_t opcode,
  input  word_t      op_a,
  input  word_t      op_b,
  input  logic       shifter_carry,
  input  flags_t     flags_in,
  output word_t      result,
  output flags_t     flags_out
);

  word_t       add_x;
  word_t       add_y;
  logic        add_cin;
  logic [32:0] sum;
  logic        arith;

  always_comb begin
    // One adder serves all arithmetic opcodes, subtraction as x + ~y + cin
    add_x   = op_a;
    add_y   = op_b;
    add_cin = 1'b0;
    arith   = 1'b1;
    case (opcode)
      OP_SUB, OP_CMP: begin
        add_y   = ~op_b;
        add_cin = 1'b1;
      end
      OP_RSB: begin
        add_x   = op_b;
        add_y   = ~op_a;
        add_cin = 1'b1;
      end
      OP_ADC: add_cin = flags_in[FLAG_C];
      OP_SBC: begin
        add_y   = ~op_b;
        add_cin = flags_in[FLAG_C];
      end
      OP_RSC: begin
        add_x   = op_b;
        add_y   = ~op_a;
        add_cin = flags_in[FLAG_C];
      end
      OP_ADD, OP_CMN: begin
      end
      default: arith = 1'b0;
    endcase

    sum = {1'b0, add_x} + {1'b0, add_y} + {32'd0, add_cin};

    case (opcode)
      OP_AND, OP_TST: result = op_a & op_b;
      OP_EOR, OP_TEQ: result = op_a ^ op_b;
      OP_ORR:         result = op_a | op_b;
      OP_MOV:         result = op_b;
      OP_BIC:         result = op_a & ~op_b;
      OP_MVN:         result = ~op_b;
      default:        result = sum[31:0];
    endcase

    flags_out[FLAG_N] = result[31];
    flags_out[FLAG_Z] = (result == '0);
    // Carry out of the adder is already not-borrow for subtraction
    flags_out[FLAG_C] = arith ? sum[32] : shifter_carry;
    flags_out[FLAG_V] = arith ? ((add_x[31] == add_y[31]) && (sum[31] != add_x[31]))
                              : flags_in[FLAG_V];
  end

endmodule : dp_alu

/* execute/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import arm_isa_pkg::*; import core_pkg::*; #(
  parameter flags_t RESET_FLAGS = '0
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        dec_valid,
  input  condition_t  cond,
  input  instr_type_t instr_type,
  input  reg_idx_t    rn,
  input  reg_idx_t    rd,
  input  dp_opcode_t  opcode,
  input  logic        set_flags,
  input  imm8_t       imm8,
  input  rotate_t     rotate,
  input  shamt_t      shamt,
  input  shift_type_t shift_type,
  input  word_t       rn_data,
  input  word_t       rm_data,
  input  word_t       rs_data,
  output logic        wr_en,
  output reg_idx_t    wr_idx,
  output word_t       wr_data,
  output logic        retire_valid,
  output reg_idx_t    retire_rd,
  output word_t       retire_result,
  output logic        retire_written,
  output logic        unsupported,
  output flags_t      flags
);

  function automatic logic cond_pass(input condition_t c, input flags_t f);
    logic n;
    logic z;
    logic cf;
    logic v;
    n  = f[FLAG_N];
    z  = f[FLAG_Z];
    cf = f[FLAG_C];
    v  = f[FLAG_V];
    case (c)
      COND_EQ: return z;
      COND_NE: return !z;
      COND_CS: return cf;
      COND_CC: return !cf;
      COND_MI: return n;
      COND_PL: return !n;
      COND_VS: return v;
      COND_VC: return !v;
      COND_HI: return cf && !z;
      COND_LS: return !cf || z;
      COND_GE: return n == v;
      COND_LT: return n != v;
      COND_GT: return !z && (n == v);
      COND_LE: return z || (n != v);
      COND_AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  word_t  shifter_operand;
  logic   shifter_carry;
  word_t  alu_result;
  flags_t alu_flags;
  logic   is_dp;
  logic   is_compare;
  logic   commit;

  operand_shifter u_shifter (
    .form       (instr_type),
    .rm_data    (rm_data),
    .rs_byte    (rs_data[7:0]),
    .shamt      (shamt),
    .shift_type (shift_type),
    .imm8       (imm8),
    .rotate     (rotate),
    .carry_in   (flags[FLAG_C]),
    .operand    (shifter_operand),
    .carry_out  (shifter_carry)
  );

  dp_alu u_alu (
    .opcode        (opcode),
    .op_a          (rn_data),
    .op_b          (shifter_operand),
    .shifter_carry (shifter_carry),
    .flags_in      (flags),
    .result        (alu_result),
    .flags_out     (alu_flags)
  );

  assign is_dp = instr_type inside {ARM_INSTR_DATAPROC_IMM, ARM_INSTR_DATAPROC_REG_IMM,
                                    ARM_INSTR_DATAPROC_REG_REG};
  assign is_compare = opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};
  assign commit = dec_valid && is_dp && cond_pass(cond, flags);

  // Register write lands on the same edge as retire
  assign wr_en   = commit && !is_compare;
  assign wr_idx  = rd;
  assign wr_data = alu_result;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags          <= RESET_FLAGS;
      retire_valid   <= 1'b0;
      retire_written <= 1'b0;
      unsupported    <= 1'b0;
    end else begin
      retire_valid   <= dec_valid && is_dp;
      retire_written <= wr_en;
      unsupported    <= dec_valid && !is_dp;
      if (commit && (set_flags || is_compare)) begin
        flags <= alu_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid && is_dp) begin
      retire_rd     <= rd;
      retire_result <= alu_result;
    end
  end

  a_retire_exclusive : assert property (
    @(posedge clk) disable iff (reset)
    !(retire_valid && unsupported)
  );

  // A dependent instruction right behind a write sees the new value
  a_write_forwarded : assert property (
    @(posedge clk) disable iff (reset)
    $past(wr_en) && (rn == $past(wr_idx)) |-> rn_data == $past(wr_data)
  );

endmodule : exec_unit

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file import arm_isa_pkg::*; import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rd_idx_a,
  input  reg_idx_t rd_idx_b,
  input  reg_idx_t rd_idx_c,
  output word_t    rd_data_a,
  output word_t    rd_data_b,
  output word_t    rd_data_c,
  input  logic     wr_en,
  input  reg_idx_t wr_idx,
  input  word_t    wr_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Reads see the array directly, no bypass needed
  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];
  assign rd_data_c = regs[rd_idx_c];

endmodule : reg_file

/* rtl/dp_core.sv */
`timescale 1ns/1ps

module dp_core import arm_isa_pkg::*; import core_pkg::*; #(
  parameter flags_t RESET_FLAGS = '0
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     instr_valid,
  input  instr_t   instr,
  output logic     retire_valid,
  output reg_idx_t retire_rd,
  output word_t    retire_result,
  output logic     retire_written,
  output logic     unsupported,
  output flags_t   flags
);

  logic        dec_valid;
  condition_t  cond;
  instr_type_t instr_type;
  reg_idx_t    rn;
  reg_idx_t    rd;
  reg_idx_t    rs;
  reg_idx_t    rm;
  dp_opcode_t  opcode;
  logic        set_flags;
  imm8_t       imm8;
  rotate_t     rotate;
  shamt_t      shamt;
  shift_type_t shift_type;
  word_t       rn_data;
  word_t       rm_data;
  word_t       rs_data;
  logic        wr_en;
  reg_idx_t    wr_idx;
  word_t       wr_data;

  instr_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec_valid   (dec_valid),
    .cond        (cond),
    .instr_type  (instr_type),
    .rn          (rn),
    .rd          (rd),
    .rs          (rs),
    .rm          (rm),
    .opcode      (opcode),
    .set_flags   (set_flags),
    .imm8        (imm8),
    .rotate      (rotate),
    .shamt       (shamt),
    .shift_type  (shift_type)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .reset     (reset),
    .rd_idx_a  (rn),
    .rd_idx_b  (rm),
    .rd_idx_c  (rs),
    .rd_data_a (rn_data),
    .rd_data_b (rm_data),
    .rd_data_c (rs_data),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data)
  );

  exec_unit #(
    .RESET_FLAGS (RESET_FLAGS)
  ) u_exec (
    .clk            (clk),
    .reset          (reset),
    .dec_valid      (dec_valid),
    .cond           (cond),
    .instr_type     (instr_type),
    .rn             (rn),
    .rd             (rd),
    .opcode         (opcode),
    .set_flags      (set_flags),
    .imm8           (imm8),
    .rotate         (rotate),
    .shamt          (shamt),
    .shift_type     (shift_type),
    .rn_data        (rn_data),
    .rm_data        (rm_data),
    .rs_data        (rs_data),
    .wr_en          (wr_en),
    .wr_idx         (wr_idx),
    .wr_data        (wr_data),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_result  (retire_result),
    .retire_written (retire_written),
    .unsupported    (unsupported),
    .flags          (flags)
  );

endmodule : dp_core

/* testbench/tb_dp_core.sv */
`timescale 1ns/1ps

module tb_dp_core
  import arm_isa_pkg::*;
  import core_pkg::*;
();

  localparam flags_t TB_RESET_FLAGS = 4'b0110;
  localparam int RESET_CYCLES = 16;
  // Instructions issued per test, in test order
  localparam int TOTAL_INSTRS = 1 + 12 + 44 + 144 + 70 + 32;
  localparam int CYCLE_LIMIT = 4 * TOTAL_INSTRS + RESET_CYCLES;

  logic     clk;
  logic     reset;
  logic     instr_valid;
  instr_t   instr;
  logic     retire_valid;
  reg_idx_t retire_rd;
  word_t    retire_result;
  logic     retire_written;
  logic     unsupported;
  flags_t   flags;

  int cycle = 0;
  int errors = 0;
  int checks = 0;
  logic [15:0] lfsr_state = 16'd48;

  // Reference model state, updated in program order at issue
  word_t  model_regs [16];
  flags_t model_flags;

  // Expected retirements, oldest first
  logic     exp_dp_q [$];
  reg_idx_t exp_rd_q [$];
  word_t    exp_res_q [$];
  logic     exp_chk_q [$];
  logic     exp_wr_q [$];
  flags_t   exp_flags_q [$];
  int       exp_cycle_q [$];

  dp_core #(
    .RESET_FLAGS (TB_RESET_FLAGS)
  ) uut (
    .clk            (clk),
    .reset          (reset),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_result  (retire_result),
    .retire_written (retire_written),
    .unsupported    (unsupported),
    .flags          (flags)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    while (cycle < CYCLE_LIMIT) @(posedge clk);
    $display("Timeout after %0d cycles, %0d instructions never retired",
             cycle, exp_dp_q.size());
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input flags_t got, input flags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic word_t rand_bits(input int n);
    word_t r;
    logic  fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic instr_t dp_imm(input condition_t c, input dp_opcode_t op, input logic s,
                                    input reg_idx_t rn, input reg_idx_t rd, input rotate_t rot,
                                    input imm8_t imm);
    return {c, 3'b001, op, s, rn, rd, rot, imm};
  endfunction

  function automatic instr_t dp_rsi(input condition_t c, input dp_opcode_t op, input logic s,
                                    input reg_idx_t rn, input reg_idx_t rd, input shamt_t sh,
                                    input shift_type_t t, input reg_idx_t rm);
    return {c, 3'b000, op, s, rn, rd, sh, t, 1'b0, rm};
  endfunction

  function automatic instr_t dp_rsr(input condition_t c, input dp_opcode_t op, input logic s,
                                    input reg_idx_t rn, input reg_idx_t rd, input reg_idx_t rs,
                                    input shift_type_t t, input reg_idx_t rm);
    return {c, 3'b000, op, s, rn, rd, rs, 1'b0, t, 1'b1, rm};
  endfunction

  // Bit-serial shifter, the carry is the last bit shifted out
  function automatic logic [32:0] ref_shift(input word_t v, input logic [1:0] t,
                                            input int amt, input logic cin);
    word_t x;
    logic  c;
    x = v;
    c = cin;
    for (int i = 0; i < amt; i++) begin
      case (t)
        2'd0: begin
          c = x[31];
          x = x << 1;
        end
        2'd1: begin
          c = x[0];
          x = x >> 1;
        end
        2'd2: begin
          c = x[0];
          x = {x[31], x[31:1]};
        end
        default: begin
          c = x[0];
          x = {x[0], x[31:1]};
        end
      endcase
    end
    return {c, x};
  endfunction

  function automatic logic [32:0] ref_operand(input instr_t w, input logic cin);
    word_t      v;
    logic [1:0] t;
    int         amt;
    v   = model_regs[w[3:0]];
    t   = w[6:5];
    amt = int'(w[11:7]);
    if (w[25]) return ref_shift({24'd0, w[7:0]}, 2'd3, 2 * int'(w[11:8]), cin);
    if (w[4]) return ref_shift(v, t, int'(model_regs[w[11:8]][7:0]), cin);
    if (amt == 0) begin
      if (t == 2'd0) return {cin, v};
      // RRX
      if (t == 2'd3) return {v[0], cin, v[31:1]};
      amt = 32;
    end
    return ref_shift(v, t, amt, cin);
  endfunction

  // Conditions come in pairs, the low bit inverts the test
  function automatic logic ref_cond(input logic [3:0] c, input flags_t f);
    logic base;
    case (c[3:1])
      3'd0: base = f[FLAG_Z];
      3'd1: base = f[FLAG_C];
      3'd2: base = f[FLAG_N];
      3'd3: base = f[FLAG_V];
      3'd4: base = f[FLAG_C] && !f[FLAG_Z];
      3'd5: base = f[FLAG_N] == f[FLAG_V];
      3'd6: base = !f[FLAG_Z] && (f[FLAG_N] == f[FLAG_V]);
      default: base = 1'b1;
    endcase
    return c[0] ? !base : base;
  endfunction

  task automatic ref_alu(input logic [3:0] op, input word_t a, input word_t b, input logic shc,
                         input flags_t fin, output word_t res, output flags_t fout);
    word_t       x;
    word_t       y;
    logic        cin;
    logic        is_sub;
    logic        arith;
    logic [33:0] u;
    longint      s;
    x      = a;
    y      = b;
    cin    = 1'b0;
    is_sub = 1'b0;
    arith  = 1'b1;
    res    = '0;
    case (op)
      4'h0, 4'h8: begin
        res   = a & b;
        arith = 1'b0;
      end
      4'h1, 4'h9: begin
        res   = a ^ b;
        arith = 1'b0;
      end
      4'hC: begin
        res   = a | b;
        arith = 1'b0;
      end
      4'hD: begin
        res   = b;
        arith = 1'b0;
      end
      4'hE: begin
        res   = a & ~b;
        arith = 1'b0;
      end
      4'hF: begin
        res   = ~b;
        arith = 1'b0;
      end
      4'h2, 4'hA: is_sub = 1'b1;
      4'h3: begin
        is_sub = 1'b1;
        x      = b;
        y      = a;
      end
      4'h5: cin = fin[FLAG_C];
      4'h6: begin
        is_sub = 1'b1;
        cin    = !fin[FLAG_C];
      end
      4'h7: begin
        is_sub = 1'b1;
        x      = b;
        y      = a;
        cin    = !fin[FLAG_C];
      end
      default: begin
      end
    endcase
    if (arith) begin
      // For subtraction cin is the borrow, C is its absence
      if (is_sub) begin
        u = {2'b00, x} - {2'b00, y} - {33'd0, cin};
        s = longint'($signed(x)) - longint'($signed(y)) - longint'(cin);
        fout[FLAG_C] = !u[33];
      end else begin
        u = {2'b00, x} + {2'b00, y} + {33'd0, cin};
        s = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
        fout[FLAG_C] = u[32];
      end
      res = u[31:0];
      fout[FLAG_V] = (s != longint'($signed(res)));
    end else begin
      fout[FLAG_C] = shc;
      fout[FLAG_V] = fin[FLAG_V];
    end
    fout[FLAG_N] = res[31];
    fout[FLAG_Z] = (res == '0);
  endtask

  // Drives one strobe and queues the model's expectation
  task automatic issue(input instr_t w, input logic is_dp);
    logic [32:0] shop;
    word_t       res;
    flags_t      fl;
    logic        pass;
    logic        cmp;
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= w;
    // Counter still holds its pre-edge value, retire follows two edges later
    exp_cycle_q.push_back(cycle + 3);
    exp_dp_q.push_back(is_dp);
    if (!is_dp) begin
      exp_rd_q.push_back('0);
      exp_res_q.push_back('0);
      exp_chk_q.push_back(1'b0);
      exp_wr_q.push_back(1'b0);
    end else begin
      shop = ref_operand(w, model_flags[FLAG_C]);
      ref_alu(w[24:21], model_regs[w[19:16]], shop[31:0], shop[32], model_flags, res, fl);
      pass = ref_cond(w[31:28], model_flags);
      cmp  = (w[24:23] == 2'b10);
      if (pass && !cmp) model_regs[w[15:12]] = res;
      if (pass && (w[20] || cmp)) model_flags = fl;
      exp_rd_q.push_back(w[15:12]);
      exp_res_q.push_back(res);
      exp_chk_q.push_back(pass);
      exp_wr_q.push_back(pass && !cmp);
    end
    exp_flags_q.push_back(model_flags);
  endtask

  task automatic wait_idle();
    @(posedge clk);
    instr_valid <= 1'b0;
    while (exp_dp_q.size() != 0) @(negedge clk);
  endtask

  task automatic load_reg(input reg_idx_t r, input word_t v);
    issue(dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, r, 4'd0, v[7:0]), 1'b1);
    issue(dp_imm(COND_AL, OP_ORR, 1'b0, r, r, 4'd12, v[15:8]), 1'b1);
    issue(dp_imm(COND_AL, OP_ORR, 1'b0, r, r, 4'd8, v[23:16]), 1'b1);
    issue(dp_imm(COND_AL, OP_ORR, 1'b0, r, r, 4'd4, v[31:24]), 1'b1);
  endtask

  task automatic end_test(input string name, input int err0);
    $display("Test %s finished with %0d errors", name, errors - err0);
  endtask

  always @(negedge clk) begin : retire_monitor
    int ecyc;
    logic edp;
    if (!reset && (retire_valid || unsupported)) begin
      if (exp_dp_q.size() == 0) begin
        errors++;
        $display("Retire at %0t with no instruction in flight", $time);
      end else begin
        ecyc = exp_cycle_q.pop_front();
        edp  = exp_dp_q.pop_front();
        if (cycle != ecyc) begin
          errors++;
          $display("Retire at %0t came in cycle %0d instead of cycle %0d", $time, cycle, ecyc);
        end
        check_bit("retire_valid", retire_valid, edp);
        check_bit("unsupported", unsupported, !edp);
        check_bit("retire_written", retire_written, exp_wr_q.pop_front());
        if (edp) check_idx("retire_rd", retire_rd, exp_rd_q.pop_front());
        else void'(exp_rd_q.pop_front());
        if (exp_chk_q.pop_front()) check_word("retire_result", retire_result, exp_res_q[0]);
        void'(exp_res_q.pop_front());
        check_flags("flags", flags, exp_flags_q.pop_front());
      end
    end
  end

  task automatic test_reset_and_first_mov();
    int err0;
    err0 = errors;
    check_flags("flags", flags, TB_RESET_FLAGS);
    check_bit("retire_valid", retire_valid, 1'b0);
    check_bit("unsupported", unsupported, 1'b0);
    check_bit("retire_written", retire_written, 1'b0);
    issue(dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd1, 4'd1, 8'h3F), 1'b1);
    wait_idle();
    end_test("reset_and_first_mov", err0);
  endtask

  task automatic test_imm_rotate();
    int      err0;
    word_t   rnd;
    rotate_t rot;
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      rnd = rand_bits(16);
      issue(dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, rnd[15:12], rnd[11:8], rnd[7:0]), 1'b1);
    end
    // MOVS, the last one with rotate zero keeps C
    for (int i = 0; i < 4; i++) begin
      rnd = rand_bits(16);
      rot = rnd[11:8];
      if (rot == 4'd0) rot = 4'd1;
      if (i == 3) rot = 4'd0;
      issue(dp_imm(COND_AL, OP_MOV, 1'b1, 4'd0, rnd[15:12], rot, rnd[7:0]), 1'b1);
    end
    wait_idle();
    end_test("imm_rotate", err0);
  endtask

  task automatic test_shifts();
    int     err0;
    word_t  rnd;
    shamt_t sh;
    imm8_t  amt;
    err0 = errors;
    load_reg(4'd1, rand_bits(32));
    for (int t = 0; t < 4; t++) begin
      issue(dp_rsi(COND_AL, OP_MOV, 1'b1, 4'd0, 4'd2, 5'd0, shift_type_t'(t[1:0]), 4'd1), 1'b1);
      rnd = rand_bits(5);
      sh  = (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0];
      issue(dp_rsi(COND_AL, OP_MOV, 1'b1, 4'd0, 4'd2, sh, shift_type_t'(t[1:0]), 4'd1), 1'b1);
    end
    // Shift bytes 0, 1 to 31, exactly 32, above 32
    for (int t = 0; t < 4; t++) begin
      for (int k = 0; k < 4; k++) begin
        rnd = rand_bits(7);
        case (k)
          0: amt = 8'd0;
          1: amt = (rnd[4:0] == 5'd0) ? 8'd1 : {3'd0, rnd[4:0]};
          2: amt = 8'd32;
          default: amt = {1'b1, rnd[6:0]};
        endcase
        issue(dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd3, 4'd0, amt), 1'b1);
        issue(dp_rsr(COND_AL, OP_MOV, 1'b1, 4'd0, 4'd4, 4'd3, shift_type_t'(t[1:0]), 4'd1),
              1'b1);
      end
    end
    wait_idle();
    end_test("shifts", err0);
  endtask

  task automatic test_opcodes();
    int err0;
    err0 = errors;
    for (int op = 0; op < 16; op++) begin
      load_reg(4'd5, rand_bits(32));
      load_reg(4'd6, rand_bits(32));
      issue(dp_rsi(COND_AL, dp_opcode_t'(op[3:0]), 1'b1, 4'd5, 4'd7, 5'd0, SHIFT_LSL, 4'd6),
            1'b1);
    end
    wait_idle();
    end_test("opcodes", err0);
  endtask

  task automatic test_conditions();
    int    err0;
    word_t ra;
    word_t rb;
    err0 = errors;
    for (int c = 0; c < 16; c++) begin
      ra = rand_bits(12);
      rb = rand_bits(12);
      // Every fourth compare uses equal operands so Z gets set
      if (c % 4 == 0) rb = ra;
      issue(dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd8, ra[11:8], ra[7:0]), 1'b1);
      issue(dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd9, rb[11:8], rb[7:0]), 1'b1);
      issue(dp_rsi(COND_AL, OP_CMP, 1'b1, 4'd8, 4'd0, 5'd0, SHIFT_LSL, 4'd9), 1'b1);
      issue(dp_imm(condition_t'(c[3:0]), OP_MOV, 1'b0, 4'd0, 4'd10, 4'd0, imm8_t'(c + 1)), 1'b1);
    end
    // Dependent chain on consecutive strobes
    issue(dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd11, 4'd0, 8'd1), 1'b1);
    for (int i = 0; i < 3; i++) begin
      issue(dp_rsi(COND_AL, OP_ADD, 1'b0, 4'd11, 4'd11, 5'd0, SHIFT_LSL, 4'd11), 1'b1);
    end
    issue(dp_rsi(COND_AL, OP_ADD, 1'b1, 4'd11, 4'd12, 5'd1, SHIFT_LSL, 4'd11), 1'b1);
    issue(dp_rsi(COND_AL, OP_SUB, 1'b1, 4'd12, 4'd12, 5'd0, SHIFT_LSL, 4'd11), 1'b1);
    wait_idle();
    end_test("conditions", err0);
  endtask

  function automatic instr_t non_dp_word(input int i);
    case (i)
      0:  return 32'hE12F_FF11;  // BX r1
      1:  return 32'hE890_0003;  // LDM
      2:  return 32'hEA00_0010;  // B
      3:  return 32'hEB00_0010;  // BL
      4:  return 32'hEF00_0123;  // SWI
      5:  return 32'hE591_2000;  // LDR r2
      6:  return 32'hE101_2093;  // SWP r2
      7:  return 32'hE002_0391;  // MUL r2
      8:  return 32'hE081_2293;  // UMULL
      9:  return 32'hE191_20B3;  // LDRH register offset
      10: return 32'hE1D1_20B4;  // LDRH immediate offset
      11: return 32'hE10F_2000;  // MRS r2
      12: return 32'hE129_F003;  // MSR
      default: return 32'hE600_0010;  // Undefined
    endcase
  endfunction

  task automatic test_unsupported();
    int err0;
    err0 = errors;
    load_reg(4'd2, rand_bits(32));
    for (int i = 0; i < 14; i++) begin
      issue(non_dp_word(i), 1'b0);
      issue(dp_rsi(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd12, 5'd0, SHIFT_LSL, 4'd2), 1'b1);
    end
    wait_idle();
    end_test("unsupported", err0);
  endtask

  initial begin
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = '0;
    end
    model_flags = TB_RESET_FLAGS;
    reset       <= 1'b1;
    instr_valid <= 1'b0;
    instr       <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    test_reset_and_first_mov();
    test_imm_rotate();
    test_shifts();
    test_opcodes();
    test_conditions();
    test_unsupported();

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_dp_core

/* all.f */
common/arm_isa_pkg.sv
common/core_pkg.sv
decoder/instr_decoder.sv
execute/operand_shifter.sv
execute/dp_alu.sv
execute/exec_unit.sv
rtl/reg_file.sv
rtl/dp_core.sv
testbench/tb_dp_core.sv

/* Bender.yml */
package:
  name: dp_core

sources:
  # Packages first, the RTL depends on them
  - common/arm_isa_pkg.sv
  - common/core_pkg.sv
  - decoder/instr_decoder.sv
  - execute/operand_shifter.sv
  - execute/dp_alu.sv
  - execute/exec_unit.sv
  - rtl/reg_file.sv
  - rtl/dp_core.sv
  - target: test
    files:
      - testbench/tb_dp_core.sv
